//--- all.f
rtl/soc_pkg.sv
rtl/tcm_ctrl.sv
rtl/gpio_ctrl.sv
rtl/tcm_arbiter.sv
rtl/soc_simple.sv
tests/soc_simple_chk.sv
tests/soc_simple_tb.sv

//--- rtl/gpio_ctrl.sv
// GPIO_W must not exceed the 32-bit bus word, and gpio_in takes two cycles to become readable
`timescale 1ns/1ps

module gpio_ctrl #(
   parameter int GPIO_W = 16                    // Pad count
) (
   input  logic                        clk_in,
   input  logic                        arst_n,
   input  logic                        en,       // One-cycle strobe
   input  logic                        we,
   input  logic [1:0]                  reg_idx,
   input  logic [3:0]                  bytesel,
   input  logic [soc_pkg::DATA_W-1:0]  din,
   input  logic [GPIO_W-1:0]           gpio_in,  // Asynchronous pins
   output logic [soc_pkg::DATA_W-1:0]  dout,
   output logic                        ready_nxt,
   output logic [GPIO_W-1:0]           gpio_out
);

   localparam int DW = soc_pkg::DATA_W;

   logic [GPIO_W-1:0] in_meta;                   // First sync stage
   logic [GPIO_W-1:0] in_sync;                   // Safe to read
   logic [DW-1:0]     byte_mask;
   logic [GPIO_W-1:0] wr_mask;
   logic [GPIO_W-1:0] wr_bits;                   // Masked write data

   // Expand lane enables to bit mask
   always_comb begin
      for (int i = 0; i < 4; i++)
         byte_mask[8*i +: 8] = {8{bytesel[i]}};
   end

   assign wr_mask = byte_mask[GPIO_W-1:0];
   assign wr_bits = din[GPIO_W-1:0] & wr_mask;

   // Two-flop input synchronizer
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         in_meta <= '0;
         in_sync <= '0;
      end else begin
         in_meta <= gpio_in;
         in_sync <= in_meta;
      end
   end

   // Output register with set and toggle writes
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         gpio_out <= '0;
      end else if (en && we) begin
         case (reg_idx)
            soc_pkg::GPIO_REG_OUT: gpio_out <= (gpio_out & ~wr_mask) | wr_bits;
            soc_pkg::GPIO_REG_TGL: gpio_out <= gpio_out ^ wr_bits;  // Flip ones only
            default:               gpio_out <= gpio_out;            // IN and hole ignore writes
         endcase
      end
   end

   // Registered read data
   always_ff @(posedge clk_in) begin
      if (en && !we) begin
         case (reg_idx)
            soc_pkg::GPIO_REG_OUT: dout <= DW'(gpio_out);
            soc_pkg::GPIO_REG_IN:  dout <= DW'(in_sync);
            soc_pkg::GPIO_REG_TGL: dout <= DW'(gpio_out);  // Toggle reads back the outputs
            default:               dout <= '0;
         endcase
      end
   end

   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n)
         ready_nxt <= 1'b0;
      else
         ready_nxt <= en;
   end

endmodule

//--- rtl/soc_pkg.sv
// Map decodes bits 16 and 15 only, so each TCM window is 32 KB and GPIO owns every address with bit 16 set
package soc_pkg;

   localparam int DATA_W = 32;        // Bus word
   localparam int ADDR_W = 32;        // Master address
   localparam int OFFS_W = 15;        // Byte offset inside one TCM window

   // Bank bit of the mem view
   localparam logic BANK_CODE = 1'b0; // 0x0000 to 0x7FFF
   localparam logic BANK_DATA = 1'b1; // 0x8000 to 0xFFFF

   // GPIO register indices, index 3 is a hole
   localparam logic [1:0] GPIO_REG_OUT = 2'd0;
   localparam logic [1:0] GPIO_REG_IN  = 2'd1;
   localparam logic [1:0] GPIO_REG_TGL = 2'd2;

   // One address word, read as memory or as peripheral
   typedef union packed {
      struct packed {
         logic [ADDR_W-18:0] pad;     // 31:17
         logic               periph;  // 16
         logic               bank;    // 15
         logic [OFFS_W-1:0]  offset;  // Byte offset in the bank
      } mem;
      struct packed {
         logic [ADDR_W-18:0] pad_hi;  // 31:17
         logic               periph;  // Same bit as in mem view
         logic [11:0]        pad_lo;  // 15:4
         logic [1:0]         reg_idx; // Register select
         logic [1:0]         byte_off;
      } periph;
   } bus_addr_u;

endpackage

//--- rtl/soc_simple.sv
// Masters are bare ports with one access each in flight and no error response, GPIO pins are not padded
`timescale 1ns/1ps

module soc_simple #(
   parameter int TCM_AW = 13,                   // 32 KB per TCM
   parameter int GPIO_W = 16
) (
   input  logic                        clk_in,
   input  logic                        arst_n,
   // Fetch port
   input  logic                        code_req,
   input  logic [soc_pkg::ADDR_W-1:0]  code_addr,
   output logic                        code_ready,
   output logic [soc_pkg::DATA_W-1:0]  code_rdata,
   output logic                        fetch_fault,
   // Load/store port
   input  logic                        data_req,
   input  logic                        data_we,
   input  logic [soc_pkg::ADDR_W-1:0]  data_addr,
   input  logic [3:0]                  data_bytesel,
   input  logic [soc_pkg::DATA_W-1:0]  data_wdata,
   output logic                        data_ready,
   output logic [soc_pkg::DATA_W-1:0]  data_rdata,
   // Pins
   input  logic [GPIO_W-1:0]           gpio_in,
   output logic [GPIO_W-1:0]           gpio_out
);

   // Code TCM side
   logic                        code_tcm_en;
   logic                        code_tcm_we;
   logic [soc_pkg::OFFS_W-1:0]  code_tcm_addr;
   logic [3:0]                  code_tcm_bytesel;
   logic [soc_pkg::DATA_W-1:0]  code_tcm_din;
   logic [soc_pkg::DATA_W-1:0]  code_tcm_dout;
   logic                        code_tcm_ready_nxt;
   // Data TCM side
   logic                        data_tcm_en;
   logic                        data_tcm_we;
   logic [soc_pkg::OFFS_W-1:0]  data_tcm_addr;
   logic [3:0]                  data_tcm_bytesel;
   logic [soc_pkg::DATA_W-1:0]  data_tcm_din;
   logic [soc_pkg::DATA_W-1:0]  data_tcm_dout;
   logic                        data_tcm_ready_nxt;
   // GPIO side
   logic                        gpio_en;
   logic                        gpio_we;
   logic [1:0]                  gpio_addr;
   logic [3:0]                  gpio_bytesel;
   logic [soc_pkg::DATA_W-1:0]  gpio_din;
   logic [soc_pkg::DATA_W-1:0]  gpio_dout;
   logic                        gpio_ready_nxt;

   tcm_arbiter u_arbiter (
      .clk_in             (clk_in),
      .arst_n             (arst_n),
      .code_req           (code_req),
      .code_addr          (code_addr),
      .code_ready         (code_ready),
      .code_rdata         (code_rdata),
      .fetch_fault        (fetch_fault),
      .data_req           (data_req),
      .data_we            (data_we),
      .data_addr          (data_addr),
      .data_bytesel       (data_bytesel),
      .data_wdata         (data_wdata),
      .data_ready         (data_ready),
      .data_rdata         (data_rdata),
      .code_tcm_en        (code_tcm_en),
      .code_tcm_we        (code_tcm_we),
      .code_tcm_addr      (code_tcm_addr),
      .code_tcm_bytesel   (code_tcm_bytesel),
      .code_tcm_din       (code_tcm_din),
      .code_tcm_dout      (code_tcm_dout),
      .code_tcm_ready_nxt (code_tcm_ready_nxt),
      .data_tcm_en        (data_tcm_en),
      .data_tcm_we        (data_tcm_we),
      .data_tcm_addr      (data_tcm_addr),
      .data_tcm_bytesel   (data_tcm_bytesel),
      .data_tcm_din       (data_tcm_din),
      .data_tcm_dout      (data_tcm_dout),
      .data_tcm_ready_nxt (data_tcm_ready_nxt),
      .gpio_en            (gpio_en),
      .gpio_we            (gpio_we),
      .gpio_addr          (gpio_addr),
      .gpio_bytesel       (gpio_bytesel),
      .gpio_din           (gpio_din),
      .gpio_dout          (gpio_dout),
      .gpio_ready_nxt     (gpio_ready_nxt)
   );

   tcm_ctrl #(.TCM_AW(TCM_AW)) u_tcm_code (   // 0x0000 window
      .clk_in    (clk_in),
      .arst_n    (arst_n),
      .en        (code_tcm_en),
      .we        (code_tcm_we),
      .addr      (code_tcm_addr),
      .bytesel   (code_tcm_bytesel),
      .din       (code_tcm_din),
      .dout      (code_tcm_dout),
      .ready_nxt (code_tcm_ready_nxt)
   );

   tcm_ctrl #(.TCM_AW(TCM_AW)) u_tcm_data (   // 0x8000 window
      .clk_in    (clk_in),
      .arst_n    (arst_n),
      .en        (data_tcm_en),
      .we        (data_tcm_we),
      .addr      (data_tcm_addr),
      .bytesel   (data_tcm_bytesel),
      .din       (data_tcm_din),
      .dout      (data_tcm_dout),
      .ready_nxt (data_tcm_ready_nxt)
   );

   gpio_ctrl #(.GPIO_W(GPIO_W)) u_gpio (
      .clk_in    (clk_in),
      .arst_n    (arst_n),
      .en        (gpio_en),
      .we        (gpio_we),
      .reg_idx   (gpio_addr),
      .bytesel   (gpio_bytesel),
      .din       (gpio_din),
      .gpio_in   (gpio_in),
      .dout      (gpio_dout),
      .ready_nxt (gpio_ready_nxt),
      .gpio_out  (gpio_out)
   );

endmodule

//--- rtl/tcm_arbiter.sv
// Data port ignores address bits 31 to 17 while a fetch with any of them set faults like a GPIO fetch
`timescale 1ns/1ps

module tcm_arbiter (
   input  logic                        clk_in,
   input  logic                        arst_n,
   // Fetch master
   input  logic                        code_req,
   input  logic [soc_pkg::ADDR_W-1:0]  code_addr,
   output logic                        code_ready,
   output logic [soc_pkg::DATA_W-1:0]  code_rdata,
   output logic                        fetch_fault,
   // Load/store master
   input  logic                        data_req,
   input  logic                        data_we,
   input  logic [soc_pkg::ADDR_W-1:0]  data_addr,
   input  logic [3:0]                  data_bytesel,
   input  logic [soc_pkg::DATA_W-1:0]  data_wdata,
   output logic                        data_ready,
   output logic [soc_pkg::DATA_W-1:0]  data_rdata,
   // Code TCM
   output logic                        code_tcm_en,
   output logic                        code_tcm_we,
   output logic [soc_pkg::OFFS_W-1:0]  code_tcm_addr,
   output logic [3:0]                  code_tcm_bytesel,
   output logic [soc_pkg::DATA_W-1:0]  code_tcm_din,
   input  logic [soc_pkg::DATA_W-1:0]  code_tcm_dout,
   input  logic                        code_tcm_ready_nxt,
   // Data TCM
   output logic                        data_tcm_en,
   output logic                        data_tcm_we,
   output logic [soc_pkg::OFFS_W-1:0]  data_tcm_addr,
   output logic [3:0]                  data_tcm_bytesel,
   output logic [soc_pkg::DATA_W-1:0]  data_tcm_din,
   input  logic [soc_pkg::DATA_W-1:0]  data_tcm_dout,
   input  logic                        data_tcm_ready_nxt,
   // GPIO
   output logic                        gpio_en,
   output logic                        gpio_we,
   output logic [1:0]                  gpio_addr,         // Register index
   output logic [3:0]                  gpio_bytesel,
   output logic [soc_pkg::DATA_W-1:0]  gpio_din,
   input  logic [soc_pkg::DATA_W-1:0]  gpio_dout,
   input  logic                        gpio_ready_nxt
);

   // Target codes
   localparam logic [1:0] TGT_CODE  = 2'd0;
   localparam logic [1:0] TGT_DATA  = 2'd1;
   localparam logic [1:0] TGT_GPIO  = 2'd2;
   localparam logic [1:0] TGT_FAULT = 2'd3;

   soc_pkg::bus_addr_u code_a;
   soc_pkg::bus_addr_u data_a;
   logic [1:0]         code_tgt;     // Decoded this cycle
   logic [1:0]         data_tgt;
   logic [1:0]         code_tgt_q;   // Owner record of the access in flight
   logic [1:0]         data_tgt_q;
   logic               code_busy;
   logic               data_busy;
   logic               fault_q;
   logic [3:0]         tgt_busy;     // Per target, bit 3 never set
   logic               code_grant;
   logic               data_grant;
   logic               data_on_code; // Data master wins code TCM
   logic               data_on_data;

   assign code_a = code_addr;
   assign data_a = data_addr;

   // Fetch decode, anything off the TCMs faults
   always_comb begin
      if (code_a.periph.periph || code_a.mem.pad != '0)
         code_tgt = TGT_FAULT;
      else if (code_a.mem.bank == soc_pkg::BANK_CODE)
         code_tgt = TGT_CODE;
      else
         code_tgt = TGT_DATA;
   end

   // Data decode never faults
   always_comb begin
      if (data_a.periph.periph)
         data_tgt = TGT_GPIO;
      else if (data_a.mem.bank == soc_pkg::BANK_DATA)
         data_tgt = TGT_DATA;
      else
         data_tgt = TGT_CODE;
   end

   // Targets with an access outstanding
   always_comb begin
      tgt_busy = '0;
      if (code_busy && code_tgt_q != TGT_FAULT)
         tgt_busy[code_tgt_q] = 1'b1;
      if (data_busy)
         tgt_busy[data_tgt_q] = 1'b1;
   end

   // Fixed data priority on a shared TCM
   assign data_grant = data_req && !data_busy && !tgt_busy[data_tgt];
   assign code_grant = code_req && !code_busy &&
                       (code_tgt == TGT_FAULT ||
                        (!tgt_busy[code_tgt] && !(data_grant && data_tgt == code_tgt)));

   assign data_on_code = data_grant && data_tgt == TGT_CODE;
   assign data_on_data = data_grant && data_tgt == TGT_DATA;

   // Code TCM steering
   assign code_tcm_en      = data_on_code || (code_grant && code_tgt == TGT_CODE);
   assign code_tcm_we      = data_on_code && data_we;             // Fetches only read
   assign code_tcm_addr    = data_on_code ? data_a.mem.offset : code_a.mem.offset;
   assign code_tcm_bytesel = data_on_code ? data_bytesel : 4'hF;
   assign code_tcm_din     = data_wdata;

   // Data TCM steering
   assign data_tcm_en      = data_on_data || (code_grant && code_tgt == TGT_DATA);
   assign data_tcm_we      = data_on_data && data_we;
   assign data_tcm_addr    = data_on_data ? data_a.mem.offset : code_a.mem.offset;
   assign data_tcm_bytesel = data_on_data ? data_bytesel : 4'hF;
   assign data_tcm_din     = data_wdata;

   // GPIO only seen by the data master
   assign gpio_en      = data_grant && data_tgt == TGT_GPIO;
   assign gpio_we      = data_we;
   assign gpio_addr    = data_a.periph.reg_idx;
   assign gpio_bytesel = data_bytesel;
   assign gpio_din     = data_wdata;

   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         code_busy  <= 1'b0;
         data_busy  <= 1'b0;
         code_tgt_q <= TGT_CODE;
         data_tgt_q <= TGT_CODE;
         fault_q    <= 1'b0;
      end else begin
         code_busy <= code_grant || (code_busy && !code_ready);   // Clears on ready
         data_busy <= data_grant || (data_busy && !data_ready);
         if (code_grant)
            code_tgt_q <= code_tgt;
         if (data_grant)
            data_tgt_q <= data_tgt;
         fault_q <= code_grant && code_tgt == TGT_FAULT;         // Completes next cycle
      end
   end

   // Return path for the fetch master
   always_comb begin
      code_ready = 1'b0;
      code_rdata = '0;
      if (code_busy) begin
         case (code_tgt_q)
            TGT_CODE: begin
               code_ready = code_tcm_ready_nxt;
               code_rdata = code_tcm_dout;
            end
            TGT_DATA: begin
               code_ready = data_tcm_ready_nxt;
               code_rdata = data_tcm_dout;
            end
            default: code_ready = fault_q;                        // Read data stays zero
         endcase
      end
   end

   assign fetch_fault = fault_q;

   // Return path for the data master
   always_comb begin
      data_ready = 1'b0;
      data_rdata = '0;
      if (data_busy) begin
         case (data_tgt_q)
            TGT_CODE: begin
               data_ready = code_tcm_ready_nxt;
               data_rdata = code_tcm_dout;
            end
            TGT_DATA: begin
               data_ready = data_tcm_ready_nxt;
               data_rdata = data_tcm_dout;
            end
            default: begin
               data_ready = gpio_ready_nxt;
               data_rdata = gpio_dout;
            end
         endcase
      end
   end

endmodule

//--- rtl/tcm_ctrl.sv
// Byte offset bits above TCM_AW+1 are ignored, so a TCM_AW below 13 aliases inside the 32 KB window
`timescale 1ns/1ps

module tcm_ctrl #(
   parameter int TCM_AW = 13                   // Word address bits
) (
   input  logic                        clk_in,
   input  logic                        arst_n,
   input  logic                        en,      // One-cycle strobe
   input  logic                        we,
   input  logic [soc_pkg::OFFS_W-1:0]  addr,    // Byte offset
   input  logic [3:0]                  bytesel,
   input  logic [soc_pkg::DATA_W-1:0]  din,
   output logic [soc_pkg::DATA_W-1:0]  dout,
   output logic                        ready_nxt
);

   logic [soc_pkg::DATA_W-1:0] mem [2**TCM_AW];
   logic [TCM_AW-1:0]          word_idx;

   assign word_idx = addr[TCM_AW+1:2];          // Drop byte lane bits

   // Write selected lanes, or latch a full word on read
   always_ff @(posedge clk_in) begin
      if (en) begin
         if (we) begin
            for (int i = 0; i < 4; i++) begin
               if (bytesel[i])
                  mem[word_idx][8*i +: 8] <= din[8*i +: 8];
            end
         end else begin
            dout <= mem[word_idx];               // Held until next read
         end
      end
   end

   // Ready pulse follows every strobe by one cycle
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n)
         ready_nxt <= 1'b0;
      else
         ready_nxt <= en;
   end

endmodule

//--- run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module soc_simple_tb \
   -Mdir obj_dir -o soc_sim

./obj_dir/soc_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
   echo "Simulation result: PASS"
   exit 0
else
   echo "Simulation result: FAIL"
   exit 1
fi

//--- tests/soc_simple_chk.sv
// Bound into every tcm_arbiter, rules sample on the rising clock and sleep while arst_n is low
`timescale 1ns/1ps

module soc_simple_chk (
   input logic clk_in,
   input logic arst_n,
   input logic code_req,
   input logic data_req,
   input logic code_ready,
   input logic data_ready,
   input logic fetch_fault,
   input logic code_tcm_en,
   input logic data_tcm_en,
   input logic gpio_en,
   input logic code_tcm_ready_nxt,   // High while the target owes its ready
   input logic data_tcm_ready_nxt,
   input logic gpio_ready_nxt
);

   // No strobe into a target that still owes a ready
   a_code_tcm_free: assert property (@(posedge clk_in) disable iff (!arst_n)
      code_tcm_en |-> !code_tcm_ready_nxt) else $error("Code TCM strobed while outstanding");
   a_data_tcm_free: assert property (@(posedge clk_in) disable iff (!arst_n)
      data_tcm_en |-> !data_tcm_ready_nxt) else $error("Data TCM strobed while outstanding");
   a_gpio_free: assert property (@(posedge clk_in) disable iff (!arst_n)
      gpio_en |-> !gpio_ready_nxt) else $error("GPIO strobed while outstanding");

   // Ready is one cycle wide
   a_code_pulse: assert property (@(posedge clk_in) disable iff (!arst_n)
      code_ready |=> !code_ready) else $error("code_ready held two cycles");
   a_data_pulse: assert property (@(posedge clk_in) disable iff (!arst_n)
      data_ready |=> !data_ready) else $error("data_ready held two cycles");

   // Master in flight holds req from the cycle it was seen until ready
   a_code_owner: assert property (@(posedge clk_in) disable iff (!arst_n)
      code_ready |-> code_req && $past(code_req))
      else $error("code_ready without a fetch in flight");
   a_data_owner: assert property (@(posedge clk_in) disable iff (!arst_n)
      data_ready |-> data_req && $past(data_req))
      else $error("data_ready without an access in flight");

   a_fault_ready: assert property (@(posedge clk_in) disable iff (!arst_n)
      fetch_fault |-> code_ready) else $error("fetch_fault without code_ready");

endmodule

bind tcm_arbiter soc_simple_chk u_chk (
   .clk_in             (clk_in),
   .arst_n             (arst_n),
   .code_req           (code_req),
   .data_req           (data_req),
   .code_ready         (code_ready),
   .data_ready         (data_ready),
   .fetch_fault        (fetch_fault),
   .code_tcm_en        (code_tcm_en),
   .data_tcm_en        (data_tcm_en),
   .gpio_en            (gpio_en),
   .code_tcm_ready_nxt (code_tcm_ready_nxt),
   .data_tcm_ready_nxt (data_tcm_ready_nxt),
   .gpio_ready_nxt     (gpio_ready_nxt)
);

//--- tests/soc_simple_tb.sv
// Run from the project root so tests/soc_vectors.txt opens, and vectors may only read TCM bytes written before
`timescale 1ns/1ps

module soc_simple_tb;

   localparam int TCM_AW = 13;
   localparam int GPIO_W = 16;
   localparam int DW     = soc_pkg::DATA_W;
   localparam int AW     = soc_pkg::ADDR_W;
   localparam int NF     = 8;                    // Fields kept per vector

   logic              clk_in;
   logic              arst_n;
   logic              code_req;
   logic [AW-1:0]     code_addr;
   logic              code_ready;
   logic [DW-1:0]     code_rdata;
   logic              fetch_fault;
   logic              data_req;
   logic              data_we;
   logic [AW-1:0]     data_addr;
   logic [3:0]        data_bytesel;
   logic [DW-1:0]     data_wdata;
   logic              data_ready;
   logic [DW-1:0]     data_rdata;
   logic [GPIO_W-1:0] gpio_in;
   logic [GPIO_W-1:0] gpio_out;

   byte               kind_q[$];                 // Vector letter
   logic [31:0]       field_q[$];                // NF fields per vector
   logic [7:0]        tcm_bytes[int];            // Byte model, key is bank and offset
   logic [GPIO_W-1:0] out_model;
   logic [GPIO_W-1:0] pin_model;
   logic [31:0]       lfsr;
   int                vec_idx;
   int                cycle_count;
   int                cycle_limit;

   soc_simple #(.TCM_AW(TCM_AW), .GPIO_W(GPIO_W)) UUT (
      .clk_in       (clk_in),
      .arst_n       (arst_n),
      .code_req     (code_req),
      .code_addr    (code_addr),
      .code_ready   (code_ready),
      .code_rdata   (code_rdata),
      .fetch_fault  (fetch_fault),
      .data_req     (data_req),
      .data_we      (data_we),
      .data_addr    (data_addr),
      .data_bytesel (data_bytesel),
      .data_wdata   (data_wdata),
      .data_ready   (data_ready),
      .data_rdata   (data_rdata),
      .gpio_in      (gpio_in),
      .gpio_out     (gpio_out)
   );

   initial begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;              // 100 ns period
   end

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "Stopped at the first error");
   endtask

   // Watchdog, limit set once the vectors are loaded
   always @(posedge clk_in) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
         report_fail($sformatf("Timeout after %0d clock cycles without finishing", cycle_limit));
   end

   task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp, input string what);
      if (got !== exp)
         report_fail($sformatf("CHECK FAILED at %0t ns: %s gave %h, expected %h",
                               $time, what, got, exp));
   endtask

   task automatic check_fault(input logic got, input logic exp, input string what);
      if (got !== exp)
         report_fail($sformatf("CHECK FAILED at %0t ns: %s gave %b, expected %b",
                               $time, what, got, exp));
   endtask

   task automatic check_pins(input logic [GPIO_W-1:0] got, input logic [GPIO_W-1:0] exp,
                             input string what);
      if (got !== exp)
         report_fail($sformatf("CHECK FAILED at %0t ns: %s gave %h, expected %h",
                               $time, what, got, exp));
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic idle_gap();
      int n;
      n = 0;
      for (int i = 0; i < 2; i++) begin
         n = 2 * n + int'(lfsr[31]);            // One step per bit
         lfsr = lfsr_next(lfsr);
      end
      repeat (n) @(negedge clk_in);
   endtask

   task automatic model_write(input logic [AW-1:0] addr, input logic [3:0] sel,
                              input logic [DW-1:0] wdata);
      logic [GPIO_W-1:0] mask;
      logic [GPIO_W-1:0] bits;
      for (int i = 0; i < GPIO_W; i++)
         mask[i] = sel[i / 8];
      bits = wdata[GPIO_W-1:0] & mask;
      if (addr[16]) begin
         if (addr[3:2] == soc_pkg::GPIO_REG_OUT)
            out_model = (out_model & ~mask) | bits;
         else if (addr[3:2] == soc_pkg::GPIO_REG_TGL)
            out_model = out_model ^ bits;       // IN and hole keep nothing
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (sel[i])
               tcm_bytes[int'({addr[15:2], i[1:0]})] = wdata[8*i +: 8];
         end
      end
   endtask

   task automatic model_read(input logic [AW-1:0] addr, output logic [DW-1:0] word);
      int key;
      word = '0;
      if (addr[16]) begin
         case (addr[3:2])
            soc_pkg::GPIO_REG_OUT: word = DW'(out_model);
            soc_pkg::GPIO_REG_TGL: word = DW'(out_model);
            soc_pkg::GPIO_REG_IN:  word = DW'(pin_model);
            default:               word = '0;
         endcase
      end else begin
         for (int i = 0; i < 4; i++) begin
            key = int'({addr[15:2], i[1:0]});
            if (!tcm_bytes.exists(key))
               report_fail($sformatf("Vector %0d reads TCM byte %h that was never written",
                                     vec_idx, key));
            else
               word[8*i +: 8] = tcm_bytes[key];
         end
      end
   endtask

   // Fetch off both TCMs gives zero and a fault
   task automatic fetch_expect(input logic [AW-1:0] addr, output logic [DW-1:0] word,
                               output logic fault);
      word  = '0;
      fault = addr[AW-1:16] != '0;
      if (!fault)
         model_read(addr, word);
   endtask

   task automatic agree_with_file(input logic [31:0] model_val, input logic [31:0] file_val);
      if (model_val !== file_val)
         report_fail($sformatf("Vector %0d in the file expects %h but the model gives %h",
                               vec_idx, file_val, model_val));
   endtask

   // Issues one or both masters in the same cycle and waits for each ready
   task automatic run_access(
      input  logic          use_code,
      input  logic [AW-1:0] c_addr,
      input  logic          use_data,
      input  logic          d_we,
      input  logic [AW-1:0] d_addr,
      input  logic [3:0]    d_sel,
      input  logic [DW-1:0] d_wdata,
      output logic [DW-1:0] c_rdata,
      output logic          c_fault,
      output logic [DW-1:0] d_rdata
   );
      logic code_done;
      logic data_done;
      code_done = !use_code;
      data_done = !use_data;
      c_rdata   = '0;
      c_fault   = 1'b0;
      d_rdata   = '0;
      @(negedge clk_in);
      code_req     = use_code;
      code_addr    = c_addr;
      data_req     = use_data;
      data_we      = d_we;
      data_addr    = d_addr;
      data_bytesel = d_sel;
      data_wdata   = d_wdata;
      while (!(code_done && data_done)) begin
         @(negedge clk_in);
         if (code_done)
            code_req = 1'b0;                     // Released one edge after ready
         if (data_done)
            data_req = 1'b0;
         c_fault = c_fault | fetch_fault;        // Any fault pulse in the window
         if (!code_done && code_ready) begin
            c_rdata   = code_rdata;
            code_done = 1'b1;
         end
         if (!data_done && data_ready) begin
            d_rdata   = data_rdata;
            data_done = 1'b1;
         end
      end
      @(negedge clk_in);
      code_req = 1'b0;
      data_req = 1'b0;
   endtask

   task automatic load_vectors();
      int          fd;
      int          got;
      int          want;
      string       cmd;
      string       rest;
      logic [31:0] val;
      fd = $fopen("tests/soc_vectors.txt", "r");
      if (fd == 0) begin
         report_fail("Could not open tests/soc_vectors.txt from the project root");
      end else begin
         while ($fscanf(fd, " %s", cmd) == 1) begin
            if (cmd[0] == "#") begin
               void'($fgets(rest, fd));          // Comment text
            end else begin
               case (cmd[0])
                  "W":     want = 3;
                  "R":     want = 2;
                  "F":     want = 3;
                  "P":     want = 8;
                  "G":     want = 1;
                  "O":     want = 1;
                  default: want = 0;
               endcase
               got = 0;
               for (int i = 0; i < NF; i++) begin
                  val = '0;
                  if (i < want)
                     got = got + $fscanf(fd, " %h", val);
                  field_q.push_back(val);
               end
               if (want == 0 || got != want || cmd.len() != 1)
                  report_fail($sformatf("Malformed vector line starting with %s", cmd));
               else
                  kind_q.push_back(cmd[0]);
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      logic [31:0]   f [NF];
      logic [DW-1:0] c_rd;
      logic [DW-1:0] d_rd;
      logic [DW-1:0] c_exp;
      logic [DW-1:0] d_exp;
      logic          c_flt;
      logic          f_exp;
      arst_n       = 1'b0;
      code_req     = 1'b0;
      code_addr    = '0;
      data_req     = 1'b0;
      data_we      = 1'b0;
      data_addr    = '0;
      data_bytesel = '0;
      data_wdata   = '0;
      gpio_in      = '0;
      out_model    = '0;
      pin_model    = '0;
      lfsr         = 32'h5043;
      vec_idx      = 0;
      cycle_count  = 0;
      cycle_limit  = 100;
      load_vectors();
      cycle_limit  = kind_q.size() * 8 + 100;
      repeat (4) @(posedge clk_in);
      @(negedge clk_in);
      arst_n = 1'b1;
      for (int v = 0; v < kind_q.size(); v++) begin
         vec_idx = v;
         for (int i = 0; i < NF; i++)
            f[i] = field_q[v*NF + i];
         idle_gap();
         case (kind_q[v])
            "W": begin
               model_write(f[0], f[1][3:0], f[2]);
               run_access(1'b0, '0, 1'b1, 1'b1, f[0], f[1][3:0], f[2], c_rd, c_flt, d_rd);
               check_fault(c_flt, 1'b0, "fetch_fault during data write");
            end
            "R": begin
               model_read(f[0], d_exp);
               agree_with_file(d_exp, f[1]);
               run_access(1'b0, '0, 1'b1, 1'b0, f[0], 4'hF, '0, c_rd, c_flt, d_rd);
               check_word(d_rd, d_exp, "data read");
               check_fault(c_flt, 1'b0, "fetch_fault during data read");
            end
            "F": begin
               fetch_expect(f[0], c_exp, f_exp);
               agree_with_file(c_exp, f[1]);
               agree_with_file(32'(f_exp), f[2]);
               run_access(1'b1, f[0], 1'b0, 1'b0, '0, '0, '0, c_rd, c_flt, d_rd);
               check_word(c_rd, c_exp, "fetch data");
               check_fault(c_flt, f_exp, "fetch_fault");
            end
            "P": begin
               d_exp = '0;
               if (f[3][0])
                  model_write(f[4], f[5][3:0], f[6]);  // Data wins a shared TCM
               else
                  model_read(f[4], d_exp);
               fetch_expect(f[0], c_exp, f_exp);
               agree_with_file(c_exp, f[1]);
               agree_with_file(32'(f_exp), f[2]);
               if (!f[3][0])
                  agree_with_file(d_exp, f[7]);
               run_access(1'b1, f[0], 1'b1, f[3][0], f[4], f[5][3:0], f[6], c_rd, c_flt, d_rd);
               check_word(c_rd, c_exp, "paired fetch data");
               check_fault(c_flt, f_exp, "paired fetch_fault");
               if (!f[3][0])
                  check_word(d_rd, d_exp, "paired data read");
            end
            "G": begin
               @(negedge clk_in);
               gpio_in   = f[0][GPIO_W-1:0];
               pin_model = f[0][GPIO_W-1:0];
               repeat (2) @(posedge clk_in);     // Both synchronizer stages
            end
            default: begin
               @(negedge clk_in);
               agree_with_file(32'(out_model), f[0]);
               check_pins(gpio_out, out_model, "gpio_out pins");
            end
         endcase
      end
      @(negedge clk_in);
      $display("Regression passed");
      $finish;
   end

endmodule

//--- tests/soc_vectors.txt
# Columns: W addr bytesel wdata | R addr expected | F addr expected fault | G pins | O pins
# P fetch_addr fetch_expected fetch_fault data_we data_addr bytesel wdata data_expected
# Byte-merged writes into both TCMs, then readback
W 00000100 F 11223344
W 00000100 2 0000AA00
W 00000104 F 00000000
W 00000104 C CAFE0000
W 00008010 F 01020304
W 00008010 9 A0FFFFB0
R 00000100 1122AA44
R 00000104 CAFE0000
R 00008010 A00203B0
# Loader path, fetch what the data port wrote
F 00000100 1122AA44 0
F 00008010 A00203B0 0
F 00000104 CAFE0000 0
# Paired accesses, same TCM and different targets
W 00000200 F 13579BDF
P 00000200 13579BDF 0 1 00000204 F 2468ACE0 00000000
P 00000100 1122AA44 0 0 00000204 F 00000000 2468ACE0
P 00008010 A00203B0 0 1 00008020 F 55AA55AA 00000000
P 00000200 13579BDF 0 0 00008020 F 00000000 55AA55AA
P 00008020 55AA55AA 0 1 00010000 1 000000A5 00000000
# Fetch faults outside the TCMs, data port does not fault
F 00010000 00000000 1
R 00010000 000000A5
F 0001000C 00000000 1
F 00020000 00000000 1
# GPIO output set and toggle
O 00A5
W 00010000 3 00001234
O 1234
W 00010008 1 000000FF
O 12CB
W 00010008 2 0000F00F
O E2CB
R 00010008 0000E2CB
R 00010000 0000E2CB
W 00010004 F FFFFFFFF
R 0001000C 00000000
O E2CB
# GPIO input through the synchronizer
G BEEF
R 00010004 0000BEEF
G 0F0F
R 00010004 00000F0F
P 00010004 00000000 1 0 00010004 F 00000000 00000F0F
